/* source/audio_cal_pkg.sv */
`default_nettype none

package audio_cal_pkg;

    // width of codec samples and of the computed DC offset
    localparam int sample_width = 16;

    // the calibration averages 2**avg_log2 strobed samples so the mean
    // is a plain arithmetic shift of the running sum
    localparam int avg_log2 = 10;
    localparam int avg_count = 1 << avg_log2;

    // the sum of avg_count full scale samples fits without overflow
    localparam int acc_width = sample_width + avg_log2;

    // unsigned fixed point gain with gain_frac fractional bits
    localparam int gain_width = 8;
    localparam int gain_frac = 6;

    // unity gain, applied until software writes something else
    localparam int gain_reset = 1 << gain_frac;

    // credits granted by the downstream consumer after reset
    localparam int credit_depth = 4;

    // counter must hold credit_depth itself, not just credit_depth - 1
    localparam int credit_width = 3;

endpackage

`default_nettype wire

/* source/audio_reg_pkg.sv */
`default_nettype none

package audio_reg_pkg;

    localparam int reg_addr_width = 2;
    localparam int reg_width = 16;

    // register map
    localparam logic [reg_addr_width-1:0] addr_ctrl = 2'd0;
    localparam logic [reg_addr_width-1:0] addr_gain = 2'd1;
    localparam logic [reg_addr_width-1:0] addr_offset = 2'd2;

    // bit positions in the control word
    localparam int ctrl_correct_en_bit = 0;
    localparam int ctrl_cal_start_bit = 1;
    localparam int ctrl_clear_overrun_bit = 2;
    localparam int ctrl_cal_done_bit = 3;
    localparam int ctrl_overrun_bit = 4;
    localparam int ctrl_used_bits = ctrl_overrun_bit + 1;

    // one bus word, seen either as the control fields or as the gain value
    // depending on the address it is written to or read from
    typedef union packed {
        struct packed {
            logic [reg_width-ctrl_used_bits-1:0] reserved;
            // read only, sticky until cleared through clear_overrun
            logic overrun;
            // read only, set when a calibration finishes
            logic cal_done;
            // write one to clear, reads back as zero
            logic clear_overrun;
            // write one to start a calibration, reads back as zero
            logic cal_start;
            logic correct_en;
        } ctrl;
        struct packed {
            logic [reg_width-audio_cal_pkg::gain_width-1:0] reserved;
            logic [audio_cal_pkg::gain_width-1:0] value;
        } gain;
    } reg_word_u;

endpackage

`default_nettype wire

/* source/calculate_offset.sv */
`timescale 1ns/1ps
`default_nettype none

module calculate_offset (
    input wire audio_clk,
    input wire rst_in,
    input wire audio_trigger,
    input wire offset_trigger,
    input wire signed [audio_cal_pkg::sample_width-1:0] audio_in,
    output logic signed [audio_cal_pkg::sample_width-1:0] offset,
    output logic offset_produced
);

    logic signed [audio_cal_pkg::acc_width-1:0] acc;
    logic signed [audio_cal_pkg::acc_width-1:0] sample_ext;
    logic signed [audio_cal_pkg::acc_width-1:0] mean;
    logic [audio_cal_pkg::avg_log2:0] count;
    logic count_full;
    enum logic [1:0] {st_waiting, st_accumulating, st_computing} state;

    assign sample_ext = audio_in;
    // floor of the mean, the shift rounds toward minus infinity
    assign mean = acc >>> audio_cal_pkg::avg_log2;
    assign count_full = (count == (audio_cal_pkg::avg_log2 + 1)'(audio_cal_pkg::avg_count));

    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            state <= st_waiting;
            count <= '0;
            offset <= '0;
            offset_produced <= 1'b0;
        end else begin
            case (state)
                st_waiting: begin
                    offset <= '0;
                    offset_produced <= 1'b0;
                    count <= '0;
                    if (offset_trigger) begin
                        state <= st_accumulating;
                    end
                end
                st_accumulating: begin
                    if (audio_trigger) begin
                        // the strobe after the last sample only closes the window
                        if (count_full) begin
                            state <= st_computing;
                            offset <= mean[audio_cal_pkg::sample_width-1:0];
                            offset_produced <= 1'b1;
                        end else begin
                            count <= count + 1'b1;
                        end
                    end
                end
                st_computing: begin
                    // offset is only valid alongside the pulse
                    offset <= '0;
                    offset_produced <= 1'b0;
                    state <= st_waiting;
                end
                default: begin
                    state <= st_waiting;
                end
            endcase
        end
    end

    always_ff @(posedge audio_clk) begin
        if (state == st_waiting) begin
            acc <= '0;
        end else if (state == st_accumulating && audio_trigger && !count_full) begin
            acc <= acc + sample_ext;
        end
    end

endmodule

`default_nettype wire

/* source/offset_remover.sv */
`timescale 1ns/1ps
`default_nettype none

module offset_remover (
    input wire audio_clk,
    input wire rst_in,
    input wire audio_trigger,
    input wire offset_produced,
    input wire correct_en,
    input wire credit_return,
    input wire signed [audio_cal_pkg::sample_width-1:0] audio_in,
    input wire signed [audio_cal_pkg::sample_width-1:0] offset,
    input wire [audio_cal_pkg::gain_width-1:0] gain,
    output logic signed [audio_cal_pkg::sample_width-1:0] sample_out,
    output logic sample_valid,
    output logic overrun_event,
    output logic signed [audio_cal_pkg::sample_width-1:0] held_offset
);

    // one extra bit so that the difference of two full scale samples fits
    logic signed [audio_cal_pkg::sample_width:0] diff;
    logic signed [audio_cal_pkg::gain_width:0] gain_s;
    logic signed [audio_cal_pkg::sample_width+audio_cal_pkg::gain_width+1:0] product;
    logic signed [audio_cal_pkg::sample_width+audio_cal_pkg::gain_width+1:0] scaled;
    logic signed [audio_cal_pkg::sample_width-1:0] saturated;
    logic fits;
    logic [audio_cal_pkg::credit_width-1:0] credit_cnt;
    logic has_credit;
    logic send;

    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            held_offset <= '0;
        end else if (offset_produced) begin
            held_offset <= offset;
        end
    end

    assign diff = correct_en ? (audio_in - held_offset) : audio_in;
    // gain is unsigned so a zero on top keeps the multiply signed
    assign gain_s = {1'b0, gain};
    assign product = diff * gain_s;
    assign scaled = product >>> audio_cal_pkg::gain_frac;

    // the result fits when every bit above the output sign bit copies it
    assign fits = &scaled[$high(scaled):audio_cal_pkg::sample_width-1]
                  || ~|scaled[$high(scaled):audio_cal_pkg::sample_width-1];

    always_comb begin
        if (fits) begin
            saturated = scaled[audio_cal_pkg::sample_width-1:0];
        end else begin
            saturated = {scaled[$high(scaled)],
                         {(audio_cal_pkg::sample_width-1){~scaled[$high(scaled)]}}};
        end
    end

    assign has_credit = (credit_cnt != '0);
    assign send = audio_trigger && has_credit;

    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            credit_cnt <= audio_cal_pkg::credit_width'(audio_cal_pkg::credit_depth);
            sample_valid <= 1'b0;
            overrun_event <= 1'b0;
        end else begin
            sample_valid <= send;
            // a sample with no credit left is dropped and never stalled
            overrun_event <= audio_trigger && !has_credit;
            case ({send, credit_return})
                2'b10: credit_cnt <= credit_cnt - 1'b1;
                2'b01: credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    always_ff @(posedge audio_clk) begin
        if (send) begin
            sample_out <= saturated;
        end
    end

endmodule

`default_nettype wire

/* source/audio_cfg_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module audio_cfg_regs (
    input wire audio_clk,
    input wire rst_in,
    input wire reg_write,
    input wire [audio_reg_pkg::reg_addr_width-1:0] reg_addr,
    input wire audio_reg_pkg::reg_word_u reg_wdata,
    output audio_reg_pkg::reg_word_u reg_rdata,
    input wire offset_produced,
    input wire overrun_event,
    input wire signed [audio_cal_pkg::sample_width-1:0] held_offset,
    output logic offset_trigger,
    output logic correct_en,
    output logic [audio_cal_pkg::gain_width-1:0] gain
);

    logic ctrl_write;
    logic gain_write;
    logic cal_done;
    logic overrun;

    assign ctrl_write = reg_write && (reg_addr == audio_reg_pkg::addr_ctrl);
    assign gain_write = reg_write && (reg_addr == audio_reg_pkg::addr_gain);

    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            correct_en <= 1'b0;
            gain <= audio_cal_pkg::gain_width'(audio_cal_pkg::gain_reset);
            offset_trigger <= 1'b0;
        end else begin
            // cal_start is a strobe, only the pulse survives the write
            offset_trigger <= ctrl_write && reg_wdata.ctrl.cal_start;
            if (ctrl_write) begin
                correct_en <= reg_wdata.ctrl.correct_en;
            end
            if (gain_write) begin
                gain <= reg_wdata.gain.value;
            end
        end
    end

    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            cal_done <= 1'b0;
        end else if (ctrl_write && reg_wdata.ctrl.cal_start) begin
            // a fresh start wins over a finishing run
            cal_done <= 1'b0;
        end else if (offset_produced) begin
            cal_done <= 1'b1;
        end
    end

    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            overrun <= 1'b0;
        end else if (overrun_event) begin
            overrun <= 1'b1;
        end else if (ctrl_write && reg_wdata.ctrl.clear_overrun) begin
            overrun <= 1'b0;
        end
    end

    // read data follows reg_addr in the same cycle
    always_comb begin
        reg_rdata = '0;
        case (reg_addr)
            audio_reg_pkg::addr_ctrl: begin
                reg_rdata.ctrl.correct_en = correct_en;
                reg_rdata.ctrl.cal_done = cal_done;
                reg_rdata.ctrl.overrun = overrun;
            end
            audio_reg_pkg::addr_gain: begin
                reg_rdata.gain.value = gain;
            end
            audio_reg_pkg::addr_offset: begin
                reg_rdata = held_offset;
            end
            default: begin
                reg_rdata = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* source/audio_dc_frontend.sv */
`timescale 1ns/1ps
`default_nettype none

module audio_dc_frontend (
    input wire audio_clk,
    input wire rst_in,
    input wire audio_trigger,
    input wire reg_write,
    input wire credit_return,
    input wire signed [audio_cal_pkg::sample_width-1:0] audio_in,
    input wire [audio_reg_pkg::reg_addr_width-1:0] reg_addr,
    input wire audio_reg_pkg::reg_word_u reg_wdata,
    output audio_reg_pkg::reg_word_u reg_rdata,
    output logic signed [audio_cal_pkg::sample_width-1:0] sample_out,
    output logic sample_valid
);

    logic offset_trigger;
    logic offset_produced;
    logic correct_en;
    logic overrun_event;
    logic [audio_cal_pkg::gain_width-1:0] gain;
    logic signed [audio_cal_pkg::sample_width-1:0] offset;
    logic signed [audio_cal_pkg::sample_width-1:0] held_offset;

    audio_cfg_regs i_cfg_regs (
        .audio_clk(audio_clk),
        .rst_in(rst_in),
        .reg_write(reg_write),
        .reg_addr(reg_addr),
        .reg_wdata(reg_wdata),
        .reg_rdata(reg_rdata),
        .offset_produced(offset_produced),
        .overrun_event(overrun_event),
        .held_offset(held_offset),
        .offset_trigger(offset_trigger),
        .correct_en(correct_en),
        .gain(gain)
    );

    calculate_offset i_calculate_offset (
        .audio_clk(audio_clk),
        .rst_in(rst_in),
        .audio_trigger(audio_trigger),
        .offset_trigger(offset_trigger),
        .audio_in(audio_in),
        .offset(offset),
        .offset_produced(offset_produced)
    );

    // the remover keeps the offset, the register block only reads it back
    offset_remover i_offset_remover (
        .audio_clk(audio_clk),
        .rst_in(rst_in),
        .audio_trigger(audio_trigger),
        .offset_produced(offset_produced),
        .correct_en(correct_en),
        .credit_return(credit_return),
        .audio_in(audio_in),
        .offset(offset),
        .gain(gain),
        .sample_out(sample_out),
        .sample_valid(sample_valid),
        .overrun_event(overrun_event),
        .held_offset(held_offset)
    );

endmodule

`default_nettype wire

/* verification/audio_dc_frontend_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module audio_dc_frontend_assert (
    input wire audio_clk,
    input wire rst_in,
    input wire audio_trigger,
    input wire sample_valid,
    input wire [audio_cal_pkg::credit_width-1:0] credit_cnt,
    input wire offset_produced
);

    // an output beat is always the registered image of a strobe
    valid_follows_strobe: assert property (@(posedge audio_clk) disable iff (rst_in)
        sample_valid |-> $past(audio_trigger))
        else $error("sample_valid without a strobe in the previous cycle");

    credit_in_range: assert property (@(posedge audio_clk) disable iff (rst_in)
        credit_cnt <= audio_cal_pkg::credit_width'(audio_cal_pkg::credit_depth))
        else $error("credit counter above the granted depth");

    // a wrap would show up as a jump of more than one credit
    credit_steps_by_one: assert property (@(posedge audio_clk) disable iff (rst_in)
        (int'(credit_cnt) - int'($past(credit_cnt)) <= 1)
        && (int'($past(credit_cnt)) - int'(credit_cnt) <= 1))
        else $error("credit counter moved by more than one");

    // offset_produced reaches the remover straight from calculate_offset
    single_offset_pulse: assert property (@(posedge audio_clk) disable iff (rst_in)
        offset_produced |=> !offset_produced)
        else $error("offset_produced high for two cycles in a row");

endmodule

bind offset_remover audio_dc_frontend_assert i_remover_assert (.*);

`default_nettype wire

/* verification/tb_audio_dc_frontend.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_audio_dc_frontend;

    localparam int n_rows = 11;
    localparam int wait_limit = 64;

    logic audio_clk = 1'b0;
    logic rst_in;
    logic audio_trigger;
    logic reg_write;
    logic credit_return = 1'b0;
    logic signed [audio_cal_pkg::sample_width-1:0] audio_in;
    logic [audio_reg_pkg::reg_addr_width-1:0] reg_addr;
    audio_reg_pkg::reg_word_u reg_wdata;
    audio_reg_pkg::reg_word_u reg_rdata;
    logic signed [audio_cal_pkg::sample_width-1:0] sample_out;
    logic sample_valid;

    integer seed;
    int errors;
    int tests;
    int test_errors;
    int out_count;
    int manual_credits;
    int i;
    int target;
    int sum;
    int q;
    logic auto_credit;
    logic signed [audio_cal_pkg::sample_width-1:0] last_out;
    logic signed [audio_cal_pkg::sample_width-1:0] cal_offset;
    logic signed [audio_cal_pkg::sample_width-1:0] x;
    audio_reg_pkg::reg_word_u rd;

    string row_name [n_rows];
    logic row_en [n_rows];
    logic [audio_cal_pkg::gain_width-1:0] row_gain [n_rows];
    logic signed [audio_cal_pkg::sample_width-1:0] row_in [n_rows];
    logic signed [audio_cal_pkg::sample_width-1:0] row_exp [n_rows];

    audio_dc_frontend i_dut (.*);

    always #10 audio_clk = ~audio_clk;

    // consumer takes every sample at once and returns its credit in the same cycle
    always @(posedge audio_clk) begin
        #2;
        if (auto_credit && sample_valid) begin
            credit_return = 1'b1;
        end else if (manual_credits > 0) begin
            credit_return = 1'b1;
            manual_credits = manual_credits - 1;
        end else begin
            credit_return = 1'b0;
        end
    end

    always @(negedge audio_clk) begin
        if (!rst_in && sample_valid) begin
            out_count = out_count + 1;
            last_out = sample_out;
        end
    end

    task automatic next_drive();
        @(posedge audio_clk);
        #2;
    endtask

    task automatic write_reg(input logic [audio_reg_pkg::reg_addr_width-1:0] addr,
                             input audio_reg_pkg::reg_word_u word);
        next_drive();
        reg_write = 1'b1;
        reg_addr = addr;
        reg_wdata = word;
        next_drive();
        reg_write = 1'b0;
    endtask

    task automatic read_reg(input logic [audio_reg_pkg::reg_addr_width-1:0] addr,
                            output audio_reg_pkg::reg_word_u word);
        next_drive();
        reg_addr = addr;
        #5;
        word = reg_rdata;
    endtask

    task automatic strobe(input logic signed [audio_cal_pkg::sample_width-1:0] value);
        next_drive();
        audio_trigger = 1'b1;
        audio_in = value;
        next_drive();
        audio_trigger = 1'b0;
    endtask

    function automatic audio_reg_pkg::reg_word_u ctrl_word(input logic en, input logic start,
                                                           input logic clr, input logic done,
                                                           input logic ovr);
        audio_reg_pkg::reg_word_u w;
        w = '0;
        w.ctrl.correct_en = en;
        w.ctrl.cal_start = start;
        w.ctrl.clear_overrun = clr;
        w.ctrl.cal_done = done;
        w.ctrl.overrun = ovr;
        return w;
    endfunction

    function automatic audio_reg_pkg::reg_word_u gain_word(input logic [7:0] g);
        audio_reg_pkg::reg_word_u w;
        w = '0;
        w.gain.value = g;
        return w;
    endfunction

    // reference for the output rule, worked out in plain integers
    function automatic logic signed [15:0] corrected(input logic en, input logic [7:0] g,
                                                     input logic signed [15:0] s,
                                                     input logic signed [15:0] off);
        int v;
        v = en ? int'(s) - int'(off) : int'(s);
        v = (v * int'(g)) >>> audio_cal_pkg::gain_frac;
        if (v > 32767) begin
            v = 32767;
        end else if (v < -32768) begin
            v = -32768;
        end
        return 16'(v);
    endfunction

    task automatic check_sample(input string name,
                                input logic signed [audio_cal_pkg::sample_width-1:0] expected,
                                input logic signed [audio_cal_pkg::sample_width-1:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH %s expected %0d actual %0d", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_reg(input string name, input audio_reg_pkg::reg_word_u expected,
                             input audio_reg_pkg::reg_word_u actual);
        if (actual !== expected) begin
            $display("MISMATCH %s expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == test_errors) begin
            $display("test %s passed", name);
        end else begin
            $display("test %s failed", name);
        end
        test_errors = errors;
    endtask

    task automatic wait_outputs(input int count, input string name);
        int cycles;
        cycles = 0;
        while (out_count < count && cycles < wait_limit) begin
            @(posedge audio_clk);
            cycles++;
        end
        if (out_count < count) begin
            $display("timeout in %s: the output sample never arrived", name);
            errors++;
        end
    endtask

    task automatic wait_cal_done();
        audio_reg_pkg::reg_word_u w;
        int polls;
        polls = 0;
        read_reg(audio_reg_pkg::addr_ctrl, w);
        while (!w.ctrl.cal_done && polls < wait_limit) begin
            read_reg(audio_reg_pkg::addr_ctrl, w);
            polls++;
        end
        if (!w.ctrl.cal_done) begin
            $display("timeout: calibration did not finish");
            errors++;
        end
    endtask

    task automatic wait_credits_back();
        int cycles;
        cycles = 0;
        while (manual_credits > 0 && cycles < wait_limit) begin
            @(posedge audio_clk);
            cycles++;
        end
        if (manual_credits > 0) begin
            $display("timeout: the consumer could not return its credits");
            errors++;
        end
    endtask

    task automatic load_row(input int n, input string name, input logic en,
                            input logic [7:0] g, input logic signed [15:0] s);
        row_name[n] = name;
        row_en[n] = en;
        row_gain[n] = g;
        row_in[n] = s;
        row_exp[n] = corrected(en, g, s, cal_offset);
    endtask

    initial begin
        audio_trigger = 1'b0;
        reg_write = 1'b0;
        audio_in = '0;
        reg_addr = '0;
        reg_wdata = '0;
        rst_in = 1'b1;
        seed = 32'h37b7_1452;
        errors = 0;
        tests = 0;
        test_errors = 0;
        out_count = 0;
        manual_credits = 0;
        auto_credit = 1'b1;
        repeat (16) @(posedge audio_clk);
        #2;
        rst_in = 1'b0;

        read_reg(audio_reg_pkg::addr_ctrl, rd);
        check_reg("reset_ctrl", ctrl_word(0, 0, 0, 0, 0), rd);
        read_reg(audio_reg_pkg::addr_gain, rd);
        check_reg("reset_gain", gain_word(8'd64), rd);
        read_reg(audio_reg_pkg::addr_offset, rd);
        check_reg("reset_offset", '0, rd);
        repeat (4) next_drive();
        check_sample("reset_no_output", 16'sd0, 16'(out_count));
        end_test("reset_defaults");

        // the 1025th strobe only closes the window
        write_reg(audio_reg_pkg::addr_ctrl, ctrl_word(0, 1, 0, 0, 0));
        sum = 0;
        for (i = 0; i <= audio_cal_pkg::avg_count; i++) begin
            x = 16'(-1234 + $random(seed) % 40);
            if (i < audio_cal_pkg::avg_count) begin
                sum += int'(x);
            end
            strobe(x);
        end
        q = sum / audio_cal_pkg::avg_count;
        if (sum < 0 && q * audio_cal_pkg::avg_count != sum) begin
            q = q - 1;
        end
        cal_offset = 16'(q);
        wait_cal_done();
        read_reg(audio_reg_pkg::addr_offset, rd);
        check_sample("cal_offset", cal_offset, rd);
        read_reg(audio_reg_pkg::addr_ctrl, rd);
        check_reg("cal_done", ctrl_word(0, 0, 0, 1, 0), rd);
        end_test("calibration");

        load_row(0, "corr_unity", 1, 8'd64, -16'sd1000);
        load_row(1, "corr_at_offset", 1, 8'd64, cal_offset);
        load_row(2, "corr_double", 1, 8'd128, 16'sd3000);
        load_row(3, "corr_half_neg", 1, 8'd32, -16'sd777);
        load_row(4, "corr_sat_pos", 1, 8'd255, 16'sd30000);
        load_row(5, "corr_sat_neg", 1, 8'd255, -16'sd30000);
        load_row(6, "corr_min_input", 1, 8'd200, 16'sh8000);
        load_row(7, "corr_zero_gain", 1, 8'd0, 16'sd12345);
        load_row(8, "bypass_unity", 0, 8'd64, 16'sd5000);
        load_row(9, "bypass_scaled", 0, 8'd96, -16'sd4000);
        load_row(10, "bypass_sat", 0, 8'd255, 16'sd20000);
        for (i = 0; i < n_rows; i++) begin
            write_reg(audio_reg_pkg::addr_ctrl, ctrl_word(row_en[i], 0, 0, 0, 0));
            write_reg(audio_reg_pkg::addr_gain, gain_word(row_gain[i]));
            target = out_count + 1;
            strobe(row_in[i]);
            wait_outputs(target, row_name[i]);
            check_sample(row_name[i], row_exp[i], last_out);
            end_test(row_name[i]);
        end

        // four credits in hand, so two of the six strobes are dropped
        @(negedge audio_clk);
        auto_credit = 1'b0;
        target = out_count + audio_cal_pkg::credit_depth;
        repeat (6) strobe(16'sd1000);
        wait_outputs(target, "credit_backpressure");
        repeat (4) next_drive();
        check_sample("backpressure_count", 16'(target), 16'(out_count));
        read_reg(audio_reg_pkg::addr_ctrl, rd);
        check_reg("overrun_set", ctrl_word(0, 0, 0, 1, 1), rd);
        @(negedge audio_clk);
        manual_credits = manual_credits + audio_cal_pkg::credit_depth;
        wait_credits_back();
        write_reg(audio_reg_pkg::addr_ctrl, ctrl_word(0, 0, 1, 0, 0));
        read_reg(audio_reg_pkg::addr_ctrl, rd);
        check_reg("overrun_clear", ctrl_word(0, 0, 0, 1, 0), rd);
        @(negedge audio_clk);
        auto_credit = 1'b1;
        target = out_count + 1;
        strobe(-16'sd2000);
        wait_outputs(target, "credit_resume");
        check_sample("credit_resume", corrected(0, row_gain[n_rows-1], -16'sd2000, cal_offset),
                     last_out);
        end_test("credit_backpressure");

        $display("tests %0d, failed checks %0d", tests, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
source/audio_cal_pkg.sv
source/audio_reg_pkg.sv
source/calculate_offset.sv
source/offset_remover.sv
source/audio_cfg_regs.sv
source/audio_dc_frontend.sv
verification/audio_dc_frontend_assert.sv
verification/tb_audio_dc_frontend.sv

/* Bender.yml */
package:
  name: audio_dc_frontend

sources:
  - target: rtl
    files:
      - source/audio_cal_pkg.sv
      - source/audio_reg_pkg.sv
      - source/calculate_offset.sv
      - source/offset_remover.sv
      - source/audio_cfg_regs.sv
      - source/audio_dc_frontend.sv

  - target: test
    files:
      - source/audio_cal_pkg.sv
      - source/audio_reg_pkg.sv
      - source/calculate_offset.sv
      - source/offset_remover.sv
      - source/audio_cfg_regs.sv
      - source/audio_dc_frontend.sv
      - verification/audio_dc_frontend_assert.sv
      - verification/tb_audio_dc_frontend.sv
